/* Bender.yml */
package:
  name: rns_conv

sources:
  # Packages first, the configuration before the types
  - design/rns_cfg_pkg.sv
  - design/rns_types_pkg.sv
  # Leaf modules, then the top level
  - design/operand_loader.sv
  - design/beat_counter.sv
  - design/conv_fsm.sv
  - design/wide_mod_reduce.sv
  - design/rns_conv_top.sv
  - target: test
    files:
      - tb/rns_conv_tb.sv

/* compile.f */
design/rns_cfg_pkg.sv
design/rns_types_pkg.sv
design/operand_loader.sv
design/beat_counter.sv
design/conv_fsm.sv
design/wide_mod_reduce.sv
design/rns_conv_top.sv
tb/rns_conv_tb.sv

/* design/beat_counter.sv */
`default_nettype none

module beat_counter #(
  parameter int unsigned BEATS = rns_cfg_pkg::BEATS
) (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic cnt_clear,
  input  wire logic word_accept,
  output logic      last_word
);

  localparam int unsigned CNT_W = (BEATS > 1) ? $clog2(BEATS) : 1;

  logic [CNT_W-1:0] count_q;

  // High on the accepted word that completes the operand
  assign last_word = word_accept && (count_q == CNT_W'(BEATS - 1));

  always_ff @(posedge clk)
  begin
    if (!rst_n || cnt_clear)
    begin
      count_q <= '0;
    end
    else if (word_accept)
    begin
      if (last_word)
      begin
        count_q <= '0;
      end
      else
      begin
        count_q <= count_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/conv_fsm.sv */
`default_nettype none

module conv_fsm (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic start,
  input  wire logic word_valid,
  input  wire logic last_word,
  output logic      busy,
  output logic      done,
  output logic      cnt_clear,
  output logic      load_clear,
  output logic      word_accept,
  output logic      capture
);

  import rns_types_pkg::*;

  conv_state_t state_q;
  conv_state_t state_d;
  logic        start_ok;

  // Busy is low in IDLE and DONE so start is honoured in both
  assign start_ok    = start && !busy;
  assign cnt_clear   = start_ok;
  assign load_clear  = start_ok;
  assign word_accept = word_valid && (state_q == LOAD);
  assign capture     = (state_q == REDUCE);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
      begin
        if (start_ok)
        begin
          state_d = LOAD;
        end
      end
      LOAD:
      begin
        if (last_word)
        begin
          state_d = REDUCE;
        end
      end
      REDUCE:
      begin
        state_d = DONE;
      end
      DONE:
      begin
        state_d = start_ok ? LOAD : IDLE;
      end
      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q <= IDLE;
      busy    <= 1'b0;
      done    <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      done    <= (state_q == REDUCE);
      if (start_ok)
      begin
        busy <= 1'b1;
      end
      else if (state_q == REDUCE)
      begin
        busy <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* design/operand_loader.sv */
`default_nettype none

module operand_loader #(
  parameter int unsigned WIDTH      = rns_cfg_pkg::OPERAND_WIDTH,
  parameter int unsigned WORD_WIDTH = rns_cfg_pkg::WORD_WIDTH
) (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   load_clear,
  input  wire logic                   word_accept,
  input  wire logic [WORD_WIDTH-1:0]  word_data,
  output rns_types_pkg::operand_t     operand
);

  logic [WIDTH-1:0] shift_q;

  // Most significant word arrives first and ends up at the top
  always_ff @(posedge clk)
  begin
    if (!rst_n || load_clear)
    begin
      shift_q <= '0;
    end
    else if (word_accept)
    begin
      shift_q <= {shift_q[WIDTH-WORD_WIDTH-1:0], word_data};
    end
  end

  assign operand = shift_q;

endmodule

`default_nettype wire

/* design/rns_cfg_pkg.sv */
`default_nettype none

package rns_cfg_pkg;

  localparam int unsigned OPERAND_WIDTH = 300;
  localparam int unsigned WORD_WIDTH    = 30;
  localparam int unsigned BEATS         = OPERAND_WIDTH / WORD_WIDTH;
  localparam int unsigned NUM_MODULI    = 4;
  localparam int unsigned RESIDUE_WIDTH = 6;

  localparam int unsigned DEFAULT_MODULI [NUM_MODULI] = '{47, 53, 59, 61};

  // 2**(RESIDUE_WIDTH*index) mod modulus built up one doubling at a time
  function automatic int unsigned chunk_weight(input int unsigned index,
                                               input int unsigned modulus);
    int unsigned w;
    w = 1 % modulus;
    for (int unsigned i = 0; i < index * RESIDUE_WIDTH; i++)
    begin
      w = (w * 2) % modulus;
    end
    return w;
  endfunction

endpackage

`default_nettype wire

/* design/rns_conv_top.sv */
`default_nettype none

module rns_conv_top #(
  parameter int unsigned OPERAND_WIDTH = rns_cfg_pkg::OPERAND_WIDTH,
  parameter int unsigned WORD_WIDTH    = rns_cfg_pkg::WORD_WIDTH,
  parameter int unsigned MODULI [rns_cfg_pkg::NUM_MODULI] = rns_cfg_pkg::DEFAULT_MODULI
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  start,
  input  wire logic                  word_valid,
  input  wire logic [WORD_WIDTH-1:0] word_data,
  output logic                       busy,
  output logic                       done,
  output rns_types_pkg::residue_vec_t residues
);

  import rns_cfg_pkg::*;
  import rns_types_pkg::*;

  localparam int unsigned NUM_BEATS = OPERAND_WIDTH / WORD_WIDTH;

  logic     cnt_clear;
  logic     load_clear;
  logic     word_accept;
  logic     capture;
  logic     last_word;
  operand_t operand;

  conv_fsm fsm_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .word_valid  (word_valid),
    .last_word   (last_word),
    .busy        (busy),
    .done        (done),
    .cnt_clear   (cnt_clear),
    .load_clear  (load_clear),
    .word_accept (word_accept),
    .capture     (capture)
  );

  beat_counter #(
    .BEATS (NUM_BEATS)
  ) counter_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cnt_clear   (cnt_clear),
    .word_accept (word_accept),
    .last_word   (last_word)
  );

  operand_loader #(
    .WIDTH      (OPERAND_WIDTH),
    .WORD_WIDTH (WORD_WIDTH)
  ) loader_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_clear  (load_clear),
    .word_accept (word_accept),
    .word_data   (word_data),
    .operand     (operand)
  );

  // One reducer per modulus fed with the shared operand
  for (genvar i = 0; i < NUM_MODULI; i++)
  begin : g_chan
    wide_mod_reduce #(
      .WIDTH   (OPERAND_WIDTH),
      .MODULUS (MODULI[i])
    ) reduce_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .operand (operand),
      .capture (capture),
      .residue (residues[i])
    );
  end

endmodule

`default_nettype wire

/* design/rns_types_pkg.sv */
`default_nettype none

package rns_types_pkg;

  typedef logic [rns_cfg_pkg::RESIDUE_WIDTH-1:0] residue_t;

  // Channel 0 sits in the low bits
  typedef residue_t [rns_cfg_pkg::NUM_MODULI-1:0] residue_vec_t;

  typedef logic [rns_cfg_pkg::OPERAND_WIDTH-1:0] operand_t;

  typedef enum logic [1:0]
  {
    IDLE   = 2'd0,
    LOAD   = 2'd1,
    REDUCE = 2'd2,
    DONE   = 2'd3
  } conv_state_t;

endpackage

`default_nettype wire

/* design/wide_mod_reduce.sv */
`default_nettype none

module wide_mod_reduce #(
  parameter int unsigned WIDTH   = rns_cfg_pkg::OPERAND_WIDTH,
  parameter int unsigned MODULUS = 47
) (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire rns_types_pkg::operand_t operand,
  input  wire logic                    capture,
  output rns_types_pkg::residue_t      residue
);

  import rns_cfg_pkg::*;

  localparam int unsigned NCHUNK  = (WIDTH + RESIDUE_WIDTH - 1) / RESIDUE_WIDTH;
  localparam int unsigned PAD_W   = NCHUNK * RESIDUE_WIDTH;
  localparam int unsigned NLEAF   = 1 << $clog2(NCHUNK);
  localparam int unsigned CHUNK_MAX = (1 << RESIDUE_WIDTH) - 1;

  // Worst case with every chunk all ones and every weight MODULUS-1
  localparam int unsigned SUM_MAX = NCHUNK * CHUNK_MAX * (MODULUS - 1);
  localparam int unsigned SUM_W   = $clog2(SUM_MAX + 1);

  // Weight of one chunk position which is 2**6 mod MODULUS
  localparam int unsigned FOLD_W  = chunk_weight(1, MODULUS);

  function automatic int unsigned fold_step(input int unsigned bound);
    return CHUNK_MAX + (bound >> RESIDUE_WIDTH) * FOLD_W;
  endfunction

  // Fold until below 2*MODULUS, or until a fold no longer shrinks the bound
  function automatic int unsigned count_folds(input int unsigned bound);
    int unsigned b;
    int unsigned n;
    b = bound;
    n = 0;
    while (b >= 2 * MODULUS && fold_step(b) < b)
    begin
      b = fold_step(b);
      n++;
    end
    return n;
  endfunction

  function automatic int unsigned bound_after(input int unsigned bound,
                                              input int unsigned folds);
    int unsigned b;
    b = bound;
    for (int unsigned i = 0; i < folds; i++)
    begin
      b = fold_step(b);
    end
    return b;
  endfunction

  localparam int unsigned NFOLD = count_folds(SUM_MAX);
  // One subtract for the default moduli and more only for small ones
  localparam int unsigned NSUB  = bound_after(SUM_MAX, NFOLD) / MODULUS;

  localparam logic [SUM_W-1:0] MOD_S  = SUM_W'(MODULUS);
  localparam logic [SUM_W-1:0] FOLD_S = SUM_W'(FOLD_W);

  logic [PAD_W-1:0] padded;
  logic [SUM_W-1:0] node [2*NLEAF-1];
  logic [SUM_W-1:0] fold [NFOLD+1];
  logic [SUM_W-1:0] sub  [NSUB+1];

  assign padded = PAD_W'(operand);

  // Leaves of the adder tree with node[0] as the root
  for (genvar i = 0; i < NLEAF; i++)
  begin : g_leaf
    if (i < NCHUNK)
    begin : g_chunk
      localparam logic [RESIDUE_WIDTH-1:0] W = RESIDUE_WIDTH'(chunk_weight(i, MODULUS));
      assign node[NLEAF-1+i] = padded[i*RESIDUE_WIDTH +: RESIDUE_WIDTH] * W;
    end
    else
    begin : g_pad
      assign node[NLEAF-1+i] = '0;
    end
  end

  for (genvar j = 0; j < NLEAF - 1; j++)
  begin : g_tree
    assign node[j] = node[2*j+1] + node[2*j+2];
  end

  assign fold[0] = node[0];

  for (genvar k = 0; k < NFOLD; k++)
  begin : g_fold
    assign fold[k+1] = fold[k][RESIDUE_WIDTH-1:0] + (fold[k] >> RESIDUE_WIDTH) * FOLD_S;
  end

  assign sub[0] = fold[NFOLD];

  for (genvar k = 0; k < NSUB; k++)
  begin : g_sub
    assign sub[k+1] = (sub[k] >= MOD_S) ? sub[k] - MOD_S : sub[k];
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      residue <= '0;
    end
    else if (capture)
    begin
      residue <= RESIDUE_WIDTH'(sub[NSUB]);
    end
  end

endmodule

`default_nettype wire

/* tb/rns_conv_tb.sv */
`default_nettype none

module rns_conv_tb;

  import rns_cfg_pkg::*;
  import rns_types_pkg::*;

  localparam int unsigned PERIOD     = 40;
  localparam int unsigned MAX_GAP    = 3;
  localparam int unsigned N_RANDOM   = 8;
  localparam int unsigned N_NOISE    = 4;
  localparam int unsigned N_OPS      = 1 + 2 * N_RANDOM + 5 + N_NOISE;
  // Idle strobes, start, words with the widest gaps, latency and slack
  localparam int unsigned OP_CYCLES  = 3 + 1 + BEATS * (1 + MAX_GAP) + 8;
  localparam int unsigned WATCHDOG   = (3 + N_OPS * OP_CYCLES) * PERIOD;
  localparam int unsigned DONE_LIMIT = 8;

  logic                  clk;
  logic                  rst_n;
  logic                  start;
  logic                  word_valid;
  logic [WORD_WIDTH-1:0] word_data;
  logic                  busy;
  logic                  done;
  residue_vec_t          residues;

  // Model residues of the last finished conversion
  residue_vec_t held;
  bit           have_result;

  rns_conv_top #(
    .OPERAND_WIDTH (OPERAND_WIDTH),
    .WORD_WIDTH    (WORD_WIDTH),
    .MODULI        (DEFAULT_MODULI)
  ) dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .word_valid (word_valid),
    .word_data  (word_data),
    .busy       (busy),
    .done       (done),
    .residues   (residues)
  );

  always #(PERIOD / 2) clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string test, input longint unsigned expected,
                                 input longint unsigned actual);
    abort_run($sformatf("Fail %s expected 0x%0h actual 0x%0h", test, expected, actual));
  endtask

  // Direct wide division independent of the chunked reduction
  function automatic int unsigned model_residue(input operand_t op, input int unsigned m);
    operand_t r;
    r = op % operand_t'(m);
    return r[31:0];
  endfunction

  function automatic operand_t random_operand();
    operand_t op;
    for (int b = 0; b < BEATS; b++)
    begin
      op[b*WORD_WIDTH +: WORD_WIDTH] = WORD_WIDTH'($urandom);
    end
    return op;
  endfunction

  task automatic check_held(input string test);
    if (have_result)
    begin
      assert (residues == held) else report_mismatch({test, " held residues"}, held, residues);
    end
  endtask

  assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else abort_run("done stayed high for more than one cycle");
  assert property (@(posedge clk) disable iff (!rst_n) busy |=> (busy || done))
    else abort_run("busy dropped before done");
  assert property (@(posedge clk) disable iff (!rst_n) done |-> !busy)
    else abort_run("busy still high while done");

  // Caller is at a falling edge and start goes out on that same edge
  task automatic convert(input string name, input operand_t op, input int unsigned max_gap,
                         input bit noise);
    int unsigned gap;
    int unsigned lat;
    int unsigned want;
    if (noise)
    begin
      repeat (3)
      begin
        word_valid = 1'b1;
        word_data  = WORD_WIDTH'($urandom);
        @(negedge clk);
        assert (!busy) else abort_run({name, ": idle strobe started a conversion"});
        check_held(name);
      end
      word_valid = 1'b0;
    end
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    assert (busy) else abort_run({name, ": busy did not rise after start"});
    for (int b = BEATS - 1; b >= 0; b--)
    begin
      gap = (max_gap > 0) ? $urandom_range(max_gap, noise ? 1 : 0) : 0;
      repeat (gap)
      begin
        word_valid = 1'b0;
        word_data  = WORD_WIDTH'($urandom);
        start      = noise;
        @(negedge clk);
        check_held(name);
      end
      start      = 1'b0;
      word_valid = 1'b1;
      word_data  = op[b*WORD_WIDTH +: WORD_WIDTH];
      @(negedge clk);
      check_held(name);
    end
    word_valid = 1'b0;
    // The rising edge just passed took the final word
    lat = 0;
    while (done !== 1'b1 && lat < DONE_LIMIT)
    begin
      @(negedge clk);
      lat++;
    end
    assert (done === 1'b1) else abort_run({name, ": done never came after the final word"});
    assert (lat == 1) else report_mismatch({name, " latency"}, 1, lat);
    assert (!busy) else abort_run({name, ": busy still high at done"});
    for (int i = 0; i < NUM_MODULI; i++)
    begin
      want = model_residue(op, DEFAULT_MODULI[i]);
      assert (residues[i] == want)
        else report_mismatch($sformatf("%s mod %0d", name, DEFAULT_MODULI[i]), want, residues[i]);
      held[i] = residue_t'(want);
    end
    have_result = 1'b1;
    @(negedge clk);
    assert (!done) else abort_run({name, ": done lasted more than one cycle"});
    check_held(name);
  endtask

  initial
  begin
    #(WATCHDOG);
    abort_run("watchdog expired before all conversions finished");
  end

  initial
  begin
    operand_t base;
    operand_t op;
    clk         = 1'b0;
    rst_n       = 1'b0;
    start       = 1'b0;
    word_valid  = 1'b0;
    word_data   = '0;
    held        = '0;
    have_result = 1'b0;
    void'($urandom(32'h17fa));
    for (int i = 0; i < NUM_MODULI; i++)
    begin
      $display("modulus %0d chunk weight %0d", DEFAULT_MODULI[i],
               chunk_weight(1, DEFAULT_MODULI[i]));
    end
    repeat (3) @(negedge clk);
    assert (!busy && !done) else abort_run("busy or done high after reset");
    assert (residues == '0) else report_mismatch("reset residues", 0, residues);
    rst_n = 1'b1;
    convert("after_reset", random_operand(), 0, 1'b0);

    for (int i = 0; i < N_RANDOM; i++)
    begin
      convert($sformatf("back_to_back_%0d", i), random_operand(), 0, 1'b0);
    end
    for (int i = 0; i < N_RANDOM; i++)
    begin
      convert($sformatf("gapped_%0d", i), random_operand(), MAX_GAP, 1'b0);
    end

    convert("zero", '0, 0, 1'b0);
    convert("all_ones", '1, 0, 1'b0);
    base = random_operand() >> 12;
    op   = base * operand_t'(47 * 59);
    convert("mult_47_59", op, 0, 1'b0);
    convert("mult_47_59_minus_one", op - operand_t'(1), 0, 1'b0);
    convert("msb_only", operand_t'(1) << (OPERAND_WIDTH - 1), 0, 1'b0);

    // Idle strobes before start and start pulses during loading
    for (int i = 0; i < N_NOISE; i++)
    begin
      convert($sformatf("noise_%0d", i), random_operand(), MAX_GAP, 1'b1);
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire
